// File: src/fetch_pkg.sv
/* fetch front end shared types and constants
   address, instruction and memory line widths, reset vector, queue sizing, branch opcodes */

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// data widths
	////////////////////////////////////////////////////////////////////////////

	// byte address of an instruction, 64-bit machine
	typedef logic [63:0] addr_t;

	// one 32-bit instruction word
	typedef logic [31:0] inst_t;

	// memory line of two instructions
	// lower half at the aligned address, upper half at address + 4
	typedef logic [63:0] imem_data_t;

	// major opcode, instruction bits 31..26
	typedef logic [5:0] opcode_t;

	// branch displacement in instructions, instruction bits 20..0
	typedef logic [20:0] disp_t;

	////////////////////////////////////////////////////////////////////////////
	// fetch start and queue sizing
	////////////////////////////////////////////////////////////////////////////

	localparam addr_t RESET_PC = 64'h0;       // first fetch address after reset

	localparam int FETCH_QUEUE_DEPTH = 4;     // queue entries
	localparam int QUEUE_PTR_BITS = 2;        // head / tail pointer width
	localparam int QUEUE_COUNT_BITS = 3;      // occupancy 0..4

	// queue pointer, wraps naturally at the depth
	typedef logic [QUEUE_PTR_BITS-1:0] queue_ptr_t;

	// entry count, one bit wider than the pointer to hold a full queue
	typedef logic [QUEUE_COUNT_BITS-1:0] queue_count_t;

	////////////////////////////////////////////////////////////////////////////
	// branch opcodes
	////////////////////////////////////////////////////////////////////////////

	// unconditional branches, always predicted taken
	localparam opcode_t OP_BR = 6'h30;
	localparam opcode_t OP_BSR = 6'h34;

	// every branch opcode has 2'b11 in bits 31..30 (0x30..0x3f)
	localparam logic [1:0] BRANCH_OPCODE_HIGH = 2'd3;

endpackage

// File: src/fetch_pc.sv
/* program counter stage
   holds the fetch PC, restarts on recover and advances only when a fetch is accepted */

module fetch_pc
(
	input  logic             clock,
	input  logic             reset,

	// back end redirect after a mispredict
	input  logic             recover,
	input  fetch_pkg::addr_t recover_pc,

	// accepted fetch and where it continues
	input  logic             fetch_write,
	input  fetch_pkg::addr_t pred_next_pc,

	// current fetch address, unaligned, bit 2 picks the slot
	output fetch_pkg::addr_t fetch_address
);

	import fetch_pkg::*;

	addr_t pc_reg;   // address being fetched this cycle
	addr_t pc_next;  // value loaded at the next edge

	////////////////////////////////////////////////////////////////////////////
	// next PC selection
	////////////////////////////////////////////////////////////////////////////

	// priority: recover first, then an accepted fetch, else hold
	// fetch_write already excludes recover, the order here keeps it safe anyway
	always_comb
	begin
		pc_next = pc_reg;                 // stall, memory miss or full queue
		if (recover)
		begin
			pc_next = recover_pc;         // redirect from the back end
		end
		else if (fetch_write)
		begin
			pc_next = pred_next_pc;       // sequential or predicted target
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// PC register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc_reg <= RESET_PC;           // start vector
		end
		else
		begin
			pc_reg <= pc_next;
		end
	end

	assign fetch_address = pc_reg;    // one cycle from acceptance to new address

endmodule

// File: src/branch_predecode.sv
/* predecode stage
   splits the memory line into two slots, predicts branches statically, forms the next fetch PC */

module branch_predecode
(
	input  fetch_pkg::addr_t     fetch_address,
	input  fetch_pkg::imem_data_t imem_data,
	input  logic                 imem_valid,
	input  logic                 queue_ready,
	input  logic                 recover,

	output logic                 fetch_write,

	output logic                 slot0_valid,
	output logic                 slot1_valid,
	output fetch_pkg::inst_t     slot0_inst,
	output fetch_pkg::inst_t     slot1_inst,
	output fetch_pkg::addr_t     slot0_pc,
	output fetch_pkg::addr_t     slot1_pc,
	output logic                 slot0_pred_taken,
	output logic                 slot1_pred_taken,
	output fetch_pkg::addr_t     slot0_pred_npc,
	output fetch_pkg::addr_t     slot1_pred_npc,

	output fetch_pkg::addr_t     pred_next_pc
);

	import fetch_pkg::*;

	logic  odd_entry;     // address bit 2 set, only the upper half is fetched
	addr_t target0;       // branch targets, meaningful only for branches
	addr_t target1;
	addr_t seq_next_pc;   // fall-through fetch address

	// static rule: BR/BSR always, other branches when the displacement is negative
	function automatic logic predict_taken(input inst_t inst);
		opcode_t op;
		disp_t   disp;
		op = inst[31:26];
		disp = inst[20:0];
		if (op[5:4] != BRANCH_OPCODE_HIGH)
			return 1'b0;                              // not a branch
		return (op == OP_BR) || (op == OP_BSR) || disp[20];
	endfunction

	// pc + 4 + 4 * sext(disp)
	function automatic addr_t branch_target(input addr_t pc, input inst_t inst);
		disp_t disp;
		disp = inst[20:0];
		return pc + 64'd4 + {{41{disp[20]}}, disp, 2'b00};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// slot selection
	////////////////////////////////////////////////////////////////////////////

	assign odd_entry = fetch_address[2];

	assign slot0_inst = odd_entry ? imem_data[63:32] : imem_data[31:0];
	assign slot1_inst = imem_data[63:32];           // only used on an even entry
	assign slot0_pc = fetch_address;
	assign slot1_pc = fetch_address + 64'd4;

	// accept only with data, room for two and no redirect in flight
	assign fetch_write = imem_valid & queue_ready & ~recover;

	////////////////////////////////////////////////////////////////////////////
	// prediction
	////////////////////////////////////////////////////////////////////////////

	assign slot0_pred_taken = predict_taken(slot0_inst);
	assign slot1_pred_taken = predict_taken(slot1_inst);
	assign target0 = branch_target(slot0_pc, slot0_inst);
	assign target1 = branch_target(slot1_pc, slot1_inst);

	// per-instruction predicted successor
	assign slot0_pred_npc = slot0_pred_taken ? target0 : slot0_pc + 64'd4;
	assign slot1_pred_npc = slot1_pred_taken ? target1 : slot1_pc + 64'd4;

	// slot 1 is cut after a taken slot 0 and does not exist on an odd entry
	assign slot0_valid = fetch_write;
	assign slot1_valid = fetch_write & ~odd_entry & ~slot0_pred_taken;

	////////////////////////////////////////////////////////////////////////////
	// next fetch PC
	////////////////////////////////////////////////////////////////////////////

	assign seq_next_pc = odd_entry ? fetch_address + 64'd4 : fetch_address + 64'd8;

	// first predicted-taken slot wins, else fall through to the next line
	always_comb
	begin
		pred_next_pc = seq_next_pc;
		if (slot0_pred_taken)
			pred_next_pc = target0;
		else if (!odd_entry && slot1_pred_taken)
			pred_next_pc = target1;
	end

endmodule

// File: src/fetch_queue.sv
/* fetch queue
   four-entry circular buffer, writes up to two and pops up to two per cycle, flushed on recover */

module fetch_queue
(
	input  logic             clock,
	input  logic             reset,
	input  logic             recover,

	// predecoded slots from the fetch side
	input  logic             slot0_valid,
	input  logic             slot1_valid,
	input  fetch_pkg::inst_t slot0_inst,
	input  fetch_pkg::inst_t slot1_inst,
	input  fetch_pkg::addr_t slot0_pc,
	input  fetch_pkg::addr_t slot1_pc,
	input  logic             slot0_pred_taken,
	input  logic             slot1_pred_taken,
	input  fetch_pkg::addr_t slot0_pred_npc,
	input  fetch_pkg::addr_t slot1_pred_npc,

	// entries taken by decode this cycle, 0..2
	input  logic [1:0]       dispatch_num,

	// room for two more, counted before this cycle's pops
	output logic             queue_ready,

	// two oldest entries toward decode
	output logic             id_valid0,
	output logic             id_valid1,
	output fetch_pkg::inst_t id_inst0,
	output fetch_pkg::inst_t id_inst1,
	output fetch_pkg::addr_t id_pc0,
	output fetch_pkg::addr_t id_pc1,
	output logic             id_pred_taken0,
	output logic             id_pred_taken1,
	output fetch_pkg::addr_t id_pred_npc0,
	output fetch_pkg::addr_t id_pred_npc1
);

	import fetch_pkg::*;

	// entry storage, payload only
	inst_t inst_q      [0:FETCH_QUEUE_DEPTH-1];
	addr_t pc_q        [0:FETCH_QUEUE_DEPTH-1];
	logic  pred_q      [0:FETCH_QUEUE_DEPTH-1];
	addr_t pred_npc_q  [0:FETCH_QUEUE_DEPTH-1];

	queue_ptr_t   head;           // oldest entry
	queue_ptr_t   tail;           // next free entry
	queue_ptr_t   head_p1;
	queue_ptr_t   tail_p1;
	queue_count_t count;          // occupied entries

	queue_count_t num_write;      // entries written this cycle
	queue_count_t num_pop;        // entries removed this cycle
	queue_count_t avail;          // entries visible at the outputs

	// first written entry, slot 0 normally, slot 1 if slot 0 is empty
	inst_t wr_inst;
	addr_t wr_pc;
	logic  wr_pred;
	addr_t wr_pred_npc;
	logic  wr_second;             // both slots go in

	assign head_p1 = head + queue_ptr_t'(1);
	assign tail_p1 = tail + queue_ptr_t'(1);

	////////////////////////////////////////////////////////////////////////////
	// write and pop sizing
	////////////////////////////////////////////////////////////////////////////

	assign queue_ready = (count <= queue_count_t'(FETCH_QUEUE_DEPTH - 2));

	assign num_write = queue_count_t'(slot0_valid) + queue_count_t'(slot1_valid);
	assign wr_second = slot0_valid & slot1_valid;

	// pack valid slots in order
	assign wr_inst     = slot0_valid ? slot0_inst : slot1_inst;
	assign wr_pc       = slot0_valid ? slot0_pc : slot1_pc;
	assign wr_pred     = slot0_valid ? slot0_pred_taken : slot1_pred_taken;
	assign wr_pred_npc = slot0_valid ? slot0_pred_npc : slot1_pred_npc;

	// never pop more than is shown to decode
	assign avail = (count >= queue_count_t'(2)) ? queue_count_t'(2) : count;
	assign num_pop = (queue_count_t'(dispatch_num) > avail) ? avail
	                                                        : queue_count_t'(dispatch_num);

	////////////////////////////////////////////////////////////////////////////
	// pointers and count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset || recover)
		begin
			head  <= '0;              // flush, outputs low from the next cycle
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			head  <= head + num_pop[QUEUE_PTR_BITS-1:0];
			tail  <= tail + num_write[QUEUE_PTR_BITS-1:0];
			count <= count + num_write - num_pop;
		end
	end

	// payload write, slot valids are already low during recover
	always_ff @(posedge clock)
	begin
		if (num_write != '0)
		begin
			inst_q[tail]     <= wr_inst;
			pc_q[tail]       <= wr_pc;
			pred_q[tail]     <= wr_pred;
			pred_npc_q[tail] <= wr_pred_npc;
		end
		if (wr_second)
		begin
			inst_q[tail_p1]     <= slot1_inst;
			pc_q[tail_p1]       <= slot1_pc;
			pred_q[tail_p1]     <= slot1_pred_taken;
			pred_npc_q[tail_p1] <= slot1_pred_npc;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode outputs
	////////////////////////////////////////////////////////////////////////////

	assign id_valid0 = (count != '0);
	assign id_valid1 = (count >= queue_count_t'(2));

	assign id_inst0       = inst_q[head];
	assign id_pc0         = pc_q[head];
	assign id_pred_taken0 = pred_q[head];
	assign id_pred_npc0   = pred_npc_q[head];

	assign id_inst1       = inst_q[head_p1];
	assign id_pc1         = pc_q[head_p1];
	assign id_pred_taken1 = pred_q[head_p1];
	assign id_pred_npc1   = pred_npc_q[head_p1];

endmodule

// File: src/fetch_top.sv
/* instruction fetch front end
   PC stage, predecode and fetch queue between instruction memory and decode */

module fetch_top
(
	input  logic                  clock,
	input  logic                  reset,

	// instruction memory, answers in the same cycle
	output fetch_pkg::addr_t      imem_addr,
	input  fetch_pkg::imem_data_t imem_data,
	input  logic                  imem_valid,

	// mispredict redirect from the back end
	input  logic                  recover,
	input  fetch_pkg::addr_t      recover_pc,

	// decode side
	input  logic [1:0]            dispatch_num,
	output logic                  id_valid0,
	output logic                  id_valid1,
	output fetch_pkg::inst_t      id_inst0,
	output fetch_pkg::inst_t      id_inst1,
	output fetch_pkg::addr_t      id_pc0,
	output fetch_pkg::addr_t      id_pc1,
	output logic                  id_pred_taken0,
	output logic                  id_pred_taken1,
	output fetch_pkg::addr_t      id_pred_npc0,
	output fetch_pkg::addr_t      id_pred_npc1
);

	import fetch_pkg::*;

	addr_t fetch_address;         // PC register
	addr_t pred_next_pc;
	logic  fetch_write;           // fetch accepted this cycle
	logic  queue_ready;

	// predecoded slots
	logic  slot0_valid, slot1_valid;
	inst_t slot0_inst, slot1_inst;
	addr_t slot0_pc, slot1_pc;
	logic  slot0_pred_taken, slot1_pred_taken;
	addr_t slot0_pred_npc, slot1_pred_npc;

	assign imem_addr = {fetch_address[63:3], 3'b000};   // line aligned

	fetch_pc i_fetch_pc
	(
		.clock, .reset, .recover, .recover_pc,
		.fetch_write, .pred_next_pc, .fetch_address
	);

	branch_predecode i_branch_predecode
	(
		.fetch_address, .imem_data, .imem_valid, .queue_ready, .recover,
		.fetch_write,
		.slot0_valid, .slot1_valid, .slot0_inst, .slot1_inst,
		.slot0_pc, .slot1_pc, .slot0_pred_taken, .slot1_pred_taken,
		.slot0_pred_npc, .slot1_pred_npc,
		.pred_next_pc
	);

	fetch_queue i_fetch_queue
	(
		.clock, .reset, .recover,
		.slot0_valid, .slot1_valid, .slot0_inst, .slot1_inst,
		.slot0_pc, .slot1_pc, .slot0_pred_taken, .slot1_pred_taken,
		.slot0_pred_npc, .slot1_pred_npc,
		.dispatch_num, .queue_ready,
		.id_valid0, .id_valid1, .id_inst0, .id_inst1, .id_pc0, .id_pc1,
		.id_pred_taken0, .id_pred_taken1, .id_pred_npc0, .id_pred_npc1
	);

endmodule

// File: sim/imem_model.sv
/* instruction memory model
   combinational ROM holding a random program of ALU ops and branches, plus word lookup ports */

module imem_model
(
	input  fetch_pkg::addr_t      addr,         // line address from fetch
	input  logic                  drop,         // miss request, valid goes low
	output fetch_pkg::imem_data_t data,
	output logic                  valid,

	// single word lookup by byte address, used for checking
	input  fetch_pkg::addr_t      look_addr0,
	input  fetch_pkg::addr_t      look_addr1,
	output fetch_pkg::inst_t      look_word0,
	output fetch_pkg::inst_t      look_word1
);

	timeunit 1ns;
	timeprecision 100ps;

	import fetch_pkg::*;

	localparam int ROM_WORDS = 256;   // 1 KB, every address wraps into it

	inst_t rom [0:ROM_WORDS-1];

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// one word in four is a branch, displacement kept short (-16..15 instructions)
	initial
	begin
		logic [31:0] seed;
		opcode_t     op;
		disp_t       disp;
		seed = 32'd9551;
		for (int i = 0; i < ROM_WORDS; i++)
		begin
			seed = lcg_step(seed);
			if (seed[31:30] == 2'b00)
			begin
				op = {2'b11, seed[29:26]};               // 0x30..0x3f, BR / BSR among them
				disp = {{16{seed[21]}}, seed[21:17]};
				rom[i] = {op, seed[11:7], disp};          // ra field is don't care
			end
			else
			begin
				rom[i] = {6'h10, seed[25:0]};             // integer ALU group
			end
		end
	end

	// lower half at the aligned address, upper half at +4
	assign data = {rom[{addr[9:3], 1'b1}], rom[{addr[9:3], 1'b0}]};
	assign valid = ~drop;

	assign look_word0 = rom[look_addr0[9:2]];
	assign look_word1 = rom[look_addr1[9:2]];

endmodule

// File: sim/fetch_tb.sv
/* fetch front end testbench
   random dispatch, memory misses and redirects, checked against a reference fetch stream */

module fetch_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import fetch_pkg::*;

	localparam int RUN_CYCLES = 4000;
	localparam int IDLE_LIMIT = 100;    // cycles without a dispatch before giving up

	logic        clock = 1'b0;
	logic        reset;
	logic        recover;
	addr_t       recover_pc;
	logic [1:0]  dispatch_num;
	logic        drop;                  // forces imem_valid low
	addr_t       imem_addr;
	imem_data_t  imem_data;
	logic        imem_valid;
	logic        id_valid0, id_valid1;
	inst_t       id_inst0, id_inst1;
	addr_t       id_pc0, id_pc1;
	logic        id_pred_taken0, id_pred_taken1;
	addr_t       id_pred_npc0, id_pred_npc1;
	inst_t       prog_word0, prog_word1;   // program words at id_pc0 / id_pc1

	int          errors = 0;
	int          checks = 0;
	logic        timed_out = 1'b0;
	logic [31:0] seed = 32'd9551;
	addr_t       exp_pc;                // next PC expected at decode

	always #10 clock = ~clock;

	fetch_top i_dut
	(
		.clock, .reset, .imem_addr, .imem_data, .imem_valid, .recover, .recover_pc,
		.dispatch_num, .id_valid0, .id_valid1, .id_inst0, .id_inst1, .id_pc0, .id_pc1,
		.id_pred_taken0, .id_pred_taken1, .id_pred_npc0, .id_pred_npc1
	);

	imem_model i_imem
	(
		.addr(imem_addr), .drop, .data(imem_data), .valid(imem_valid),
		.look_addr0(id_pc0), .look_addr1(id_pc1), .look_word0(prog_word0), .look_word1(prog_word1)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// static rule, unconditional always, conditional only backward
	function automatic logic branch_taken(input inst_t w);
		if (w[31:30] != 2'b11)
			return 1'b0;
		if (w[31:26] == OP_BR || w[31:26] == OP_BSR)
			return 1'b1;
		return w[20];
	endfunction

	// successor of one instruction in the predicted stream
	function automatic addr_t stream_next(input addr_t pc, input inst_t w);
		logic signed [63:0] d;
		d = 64'($signed(w[20:0]));
		return branch_taken(w) ? pc + 64'd4 + d * 64'sd4 : pc + 64'd4;
	endfunction

	task automatic verify(input logic ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			$display("FAILED at %0t: %s", $time, what);
		end
	endtask

	task automatic check_prediction(input addr_t pc, input inst_t inst, input logic taken,
	                                input addr_t npc);
		verify(taken == branch_taken(inst),
		       $sformatf("pc %h inst %h: pred_taken %b", pc, inst, taken));
		verify(npc == stream_next(pc, inst),
		       $sformatf("pc %h: pred_npc %h, expected %h", pc, npc, stream_next(pc, inst)));
	endtask

	task automatic take_dispatched(input addr_t pc, input inst_t inst, input inst_t word);
		verify(pc == exp_pc, $sformatf("dispatched pc %h, expected %h", pc, exp_pc));
		verify(inst == word, $sformatf("pc %h: inst %h, program has %h", pc, inst, word));
		exp_pc = stream_next(pc, word);   // resyncs on a wrong pc, avoids an error cascade
	endtask

	initial
	begin
		int         idle, cycle, ref_count, bound, pick;
		addr_t      ref_pc, held_addr, last_rec_pc, nxt_rpc;
		logic       stall_prev, rec_prev, nxt_drop, nxt_rec;
		logic [1:0] nxt_disp;
		inst_t      w0;
		reset <= 1'b1;
		recover <= 1'b0;
		recover_pc <= RESET_PC;
		dispatch_num <= 2'd0;
		drop <= 1'b0;
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clock);
			verify(!id_valid0 && !id_valid1 && imem_addr == RESET_PC, "outputs not idle in reset");
		end
		@(posedge clock);
		reset <= 1'b0;
		ref_pc = RESET_PC;              // fetch side reference
		ref_count = 0;                  // queue occupancy of the current cycle
		exp_pc = RESET_PC;
		stall_prev = 1'b0;
		rec_prev = 1'b0;
		idle = 0;
		cycle = 0;
		while (cycle < RUN_CYCLES && !timed_out)
		begin
			@(negedge clock);           // outputs settled, inputs of this cycle in place
			verify(imem_addr == {ref_pc[63:3], 3'b000},
			       $sformatf("imem_addr %h, expected %h", imem_addr, ref_pc));
			if (stall_prev)
				verify(imem_addr == held_addr, "imem_addr moved after a stalled fetch");
			if (rec_prev)
				verify(!id_valid0 && !id_valid1 && imem_addr == {last_rec_pc[63:3], 3'b000},
				       $sformatf("queue not flushed or no restart at %h", last_rec_pc));
			verify(id_valid0 == (ref_count > 0) && id_valid1 == (ref_count > 1),
			       $sformatf("valids %b%b with %0d queued", id_valid1, id_valid0, ref_count));
			if (id_valid0)
				check_prediction(id_pc0, id_inst0, id_pred_taken0, id_pred_npc0);
			if (id_valid1)
				check_prediction(id_pc1, id_inst1, id_pred_taken1, id_pred_npc1);
			if (dispatch_num != 2'd0)
				take_dispatched(id_pc0, id_inst0, prog_word0);     // slot 0 first
			if (dispatch_num == 2'd2)
				take_dispatched(id_pc1, id_inst1, prog_word1);

			////////////////////////////////////////////////////////////////////////////
			// reference state for the next cycle
			////////////////////////////////////////////////////////////////////////////
			stall_prev = !recover && (drop || (dispatch_num == 2'd0 && ref_count >= 3));
			held_addr = imem_addr;
			rec_prev = recover;
			last_rec_pc = recover_pc;
			if (recover)
			begin
				ref_pc = recover_pc;    // flush, fetch restarts
				ref_count = 0;
				exp_pc = recover_pc;
			end
			else
			begin
				if (!drop && ref_count <= 2)    // room for two, counted before pops
				begin
					w0 = ref_pc[2] ? imem_data[63:32] : imem_data[31:0];
					if (ref_pc[2] || branch_taken(w0))
					begin
						ref_count = ref_count + 1;
						ref_pc = stream_next(ref_pc, w0);
					end
					else
					begin
						ref_count = ref_count + 2;   // second slot at pc + 4
						ref_pc = stream_next(ref_pc + 64'd4, imem_data[63:32]);
					end
				end
				ref_count = ref_count - int'(dispatch_num);
			end
			idle = (dispatch_num == 2'd0) ? idle + 1 : 0;
			if (idle > IDLE_LIMIT)
			begin
				timed_out = 1'b1;
				$display("timeout: nothing dispatched for %0d cycles", IDLE_LIMIT);
			end

			// next inputs, dispatch bounded by next cycle's valid outputs
			seed = lcg_next(seed);
			nxt_drop = (seed[31:29] == 3'd0);                   // about 1 in 8
			seed = lcg_next(seed);
			nxt_rec = (seed[31:27] == 5'd0);                    // about 1 in 32
			nxt_rpc = {54'd0, seed[20:13], 2'b00};              // bit 2 set half the time
			seed = lcg_next(seed);
			bound = nxt_rec ? 0 : (ref_count > 2 ? 2 : ref_count);
			pick = int'(seed[31:30]);
			nxt_disp = 2'(pick > bound ? bound : pick);
			@(posedge clock);
			drop <= nxt_drop;
			recover <= nxt_rec;
			recover_pc <= nxt_rpc;
			dispatch_num <= nxt_disp;
			cycle++;
		end
		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, int'(timed_out));
		if (errors == 0 && !timed_out)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
src/fetch_pkg.sv
src/fetch_pc.sv
src/branch_predecode.sv
src/fetch_queue.sv
src/fetch_top.sv
sim/imem_model.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module fetch_tb \
	-f verilog.f -o fetch_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -qx "RESULT: PASS" sim.log && exit 0 || exit 1
